// ==== hw/renderer_pkg.sv ====
package renderer_pkg;

    // Frame geometry
    localparam int FB_WIDTH        = 64;                          // Pixels per line
    localparam int FB_HEIGHT       = 32;                          // Lines per frame
    localparam int NUM_BANKS       = 4;                           // Column interleave factor
    localparam int GROUPS_PER_ROW  = FB_WIDTH / NUM_BANKS;        // 16 groups of 4 columns
    localparam int BANK_DEPTH      = FB_HEIGHT * GROUPS_PER_ROW;  // Words per bank
    localparam int BANK_ADDR_W     = $clog2(BANK_DEPTH);          // 9 bit word address

    // Scan timing
    localparam int PREFETCH_OFFSET = 2;                           // Pixels read ahead
    localparam int READ_LATENCY    = 3;                           // Coordinate to RGB, in cycles

    typedef struct packed {
        logic [3:0] r;                                            // Red, top nibble
        logic [3:0] g;
        logic [3:0] b;                                            // Blue, bottom nibble
    } pixel_t;

    typedef enum logic {
        OP_CLEAR     = 1'b0,                                      // Whole frame
        OP_FILL_RECT = 1'b1                                       // Inclusive rectangle
    } fill_op_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } fill_state_e;

    typedef struct packed {
        fill_op_e   op;
        logic [5:0] x0;                                           // Corners in any order
        logic [5:0] x1;
        logic [4:0] y0;
        logic [4:0] y1;
        pixel_t     color;
    } draw_cmd_t;

    typedef struct packed {
        logic [NUM_BANKS-1:0]   mask;                             // One write enable per bank
        logic [BANK_ADDR_W-1:0] addr;                             // Same word in every bank
        pixel_t                 color;
    } group_write_t;

endpackage

// ==== hw/rect_fill_engine.sv ====
`timescale 1ns/1ns

module rect_fill_engine import renderer_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         cmd_valid,                     // One-cycle command strobe
    input  draw_cmd_t    cmd,                           // Sampled with the strobe
    output logic         busy,                          // High while groups are written
    output group_write_t wr                             // Broadcast to all banks
);

    fill_state_e state;                                 // Idle or filling

    // Ordered corners of the incoming command
    logic [5:0] cmd_x0;
    logic [5:0] cmd_x1;
    logic [4:0] cmd_y0;
    logic [4:0] cmd_y1;

    // Latched rectangle
    logic [5:0] rect_x0;
    logic [5:0] rect_x1;
    logic [4:0] rect_y1;
    pixel_t     rect_color;

    logic [3:0] grp_first;                              // Group holding the left edge
    logic [3:0] grp_last;                               // Group holding the right edge

    logic [4:0] row;                                    // Current row
    logic [3:0] grp;                                    // Current column group in row
    logic [5:0] group_col [NUM_BANKS];                  // Column index per bank lane

    logic accept;
    logic last_grp;
    logic last_row;

    assign accept    = cmd_valid && (state == ST_IDLE); // Strobes during busy are dropped
    assign busy      = (state == ST_RUN);
    assign grp_first = rect_x0[5:2];
    assign grp_last  = rect_x1[5:2];
    assign last_grp  = (grp == grp_last);
    assign last_row  = (row == rect_y1);

    // CLEAR becomes a full-frame rectangle, otherwise sort the corners
    always_comb begin
        if (cmd.op == OP_CLEAR) begin
            cmd_x0 = '0;
            cmd_x1 = 6'(FB_WIDTH - 1);
            cmd_y0 = '0;
            cmd_y1 = 5'(FB_HEIGHT - 1);
        end else begin
            cmd_x0 = (cmd.x0 <= cmd.x1) ? cmd.x0 : cmd.x1;   // Left edge
            cmd_x1 = (cmd.x0 <= cmd.x1) ? cmd.x1 : cmd.x0;   // Right edge
            cmd_y0 = (cmd.y0 <= cmd.y1) ? cmd.y0 : cmd.y1;   // Top edge
            cmd_y1 = (cmd.y0 <= cmd.y1) ? cmd.y1 : cmd.y0;   // Bottom edge
        end
    end

    // Walk groups left to right, then rows top to bottom
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= ST_IDLE;
            row   <= '0;
            grp   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_RUN;
                        row   <= cmd_y0;                // Start at top-left group
                        grp   <= cmd_x0[5:2];
                    end
                end
                ST_RUN: begin
                    if (last_grp) begin
                        grp <= grp_first;               // Back to the left edge
                        if (last_row) begin
                            state <= ST_IDLE;           // Busy drops after final write
                        end else begin
                            row <= row + 5'd1;
                        end
                    end else begin
                        grp <= grp + 4'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Rectangle payload, only loaded on acceptance
    always_ff @(posedge clk_in) begin
        if (accept) begin
            rect_x0    <= cmd_x0;
            rect_x1    <= cmd_x1;
            rect_y1    <= cmd_y1;
            rect_color <= cmd.color;
        end
    end

    // Lane i covers column grp*4+i; trim lanes outside the rectangle edges
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            group_col[i] = {grp, 2'(i)};
            wr.mask[i]   = busy && (group_col[i] >= rect_x0) && (group_col[i] <= rect_x1);
        end
        wr.addr  = {row, grp};                          // row * GROUPS_PER_ROW + group
        wr.color = rect_color;
    end

    // Counters stay inside the latched rectangle during a fill
    a_walk_in_rect: assert property (@(posedge clk_in) disable iff (rst_in)
        busy |-> (grp >= grp_first) && (grp <= grp_last) && (row <= rect_y1));

    // Every busy cycle writes at least one pixel
    a_run_write_ok: assert property (@(posedge clk_in) disable iff (rst_in)
        busy |-> (wr.mask != '0));

endmodule

// ==== hw/fb_bank.sv ====
`timescale 1ns/1ns

module fb_bank import renderer_pkg::*; (
    input  logic                   clk_in,
    input  logic                   wr_en,           // This bank's mask bit
    input  logic [BANK_ADDR_W-1:0] wr_addr,
    input  pixel_t                 wr_color,
    input  logic [BANK_ADDR_W-1:0] rd_addr,         // Shared scan address
    output pixel_t                 rd_data          // Two cycles after rd_addr
);

    pixel_t mem [BANK_DEPTH];                       // One column of every group
    pixel_t mem_q;                                  // Registered memory output

    // Write port, takes effect at the edge
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_color;
        end
    end

    // Read port sees the old word on a collision, then a second output stage
    always_ff @(posedge clk_in) begin
        mem_q   <= mem[rd_addr];
        rd_data <= mem_q;                           // High-performance output register
    end

endmodule

// ==== hw/scan_prefetch_reader.sv ====
`timescale 1ns/1ns

module scan_prefetch_reader import renderer_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic [10:0]            x_in,             // Scan column
    input  logic [9:0]             y_in,             // Scan row
    input  pixel_t                 bank_data [NUM_BANKS],
    output logic [BANK_ADDR_W-1:0] rd_addr,          // Shared by all banks
    output logic [3:0]             r_out,
    output logic [3:0]             g_out,
    output logic [3:0]             b_out
);

    logic [11:0] x_ahead;                            // Column plus offset, before wrap
    logic [11:0] pre_x;                              // Wrapped prefetch column
    logic [9:0]  pre_y;                              // Prefetch row
    logic [1:0]  bank_sel;                           // Bank of the prefetch pixel

    // Select follows the two bank stages
    logic [1:0]  sel_pipe [READ_LATENCY-1];
    pixel_t      pix_sel;

    assign x_ahead = {1'b0, x_in} + 12'(PREFETCH_OFFSET);

    // Wrap at line end, and at the frame end back to row 0
    always_comb begin
        if (x_ahead >= 12'(FB_WIDTH)) begin
            pre_x = x_ahead - 12'(FB_WIDTH);
            if (y_in == 10'(FB_HEIGHT - 1)) begin
                pre_y = '0;
            end else begin
                pre_y = y_in + 10'd1;
            end
        end else begin
            pre_x = x_ahead;
            pre_y = y_in;
        end
    end

    assign rd_addr  = {pre_y[4:0], pre_x[5:2]};      // row * GROUPS_PER_ROW + x / NUM_BANKS
    assign bank_sel = pre_x[1:0];                    // x mod NUM_BANKS

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < READ_LATENCY - 1; i++) begin
                sel_pipe[i] <= '0;
            end
        end else begin
            sel_pipe[0] <= bank_sel;
            for (int i = 1; i < READ_LATENCY - 1; i++) begin
                sel_pipe[i] <= sel_pipe[i-1];
            end
        end
    end

    assign pix_sel = bank_data[sel_pipe[READ_LATENCY-2]];   // Lines up with rd_data

    // Output register, cleared by reset
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            r_out <= '0;
            g_out <= '0;
            b_out <= '0;
        end else begin
            r_out <= pix_sel.r;
            g_out <= pix_sel.g;
            b_out <= pix_sel.b;
        end
    end

    // The scan must stay inside the stored frame
    a_scan_in_frame: assert property (@(posedge clk_in) disable iff (rst_in)
        (x_in < FB_WIDTH) && (y_in < FB_HEIGHT));

endmodule

// ==== hw/three_dim_renderer.sv ====
`timescale 1ns/1ns

module three_dim_renderer import renderer_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic [10:0] x_in,                       // Scan position
    input  logic [9:0]  y_in,
    input  logic       cmd_valid,                   // Draw command strobe
    input  draw_cmd_t  cmd,
    output logic       busy,                        // Fill in progress
    output logic [3:0] r_out,                       // RGB of the prefetch pixel
    output logic [3:0] g_out,
    output logic [3:0] b_out
);

    group_write_t           fill_wr;                // Engine broadcast to banks
    logic [BANK_ADDR_W-1:0] scan_addr;              // Reader address to banks
    pixel_t                 bank_rd [NUM_BANKS];    // Bank words back to reader

    // Command to group writes
    rect_fill_engine u_fill (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .wr        (fill_wr)
    );

    // One bank per column lane
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        fb_bank u_bank (
            .clk_in   (clk_in),
            .wr_en    (fill_wr.mask[i]),            // Own lane enable
            .wr_addr  (fill_wr.addr),
            .wr_color (fill_wr.color),
            .rd_addr  (scan_addr),
            .rd_data  (bank_rd[i])
        );
    end

    // Scan position to prefetch address and RGB
    scan_prefetch_reader u_reader (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .x_in      (x_in),
        .y_in      (y_in),
        .bank_data (bank_rd),
        .rd_addr   (scan_addr),
        .r_out     (r_out),
        .g_out     (g_out),
        .b_out     (b_out)
    );

endmodule

// ==== dv/renderer_model.svh ====
`ifndef RENDERER_MODEL_SVH
`define RENDERER_MODEL_SVH

pixel_t model_frame [FB_HEIGHT][FB_WIDTH];              // Expected frame, row major

// Inclusive bounds of a command, CLEAR covers the whole frame
function automatic void model_bounds(input draw_cmd_t c, output int xl, output int xr,
                                     output int yt, output int yb);
    if (c.op == OP_CLEAR) begin
        xl = 0;
        xr = FB_WIDTH - 1;
        yt = 0;
        yb = FB_HEIGHT - 1;
    end else begin
        xl = (c.x0 < c.x1) ? int'(c.x0) : int'(c.x1);  // Corners may come swapped
        xr = (c.x0 < c.x1) ? int'(c.x1) : int'(c.x0);
        yt = (c.y0 < c.y1) ? int'(c.y0) : int'(c.y1);
        yb = (c.y0 < c.y1) ? int'(c.y1) : int'(c.y0);
    end
endfunction

// Paint an accepted command into the expected frame
task automatic model_apply(input draw_cmd_t c);
    int xl;
    int xr;
    int yt;
    int yb;
    model_bounds(c, xl, xr, yt, yb);
    for (int y = yt; y <= yb; y++) begin
        for (int x = xl; x <= xr; x++) begin
            model_frame[y][x] = c.color;
        end
    end
endtask

// Busy length: one cycle per group of four columns touched, per row
function automatic int model_busy_cycles(input draw_cmd_t c);
    int xl;
    int xr;
    int yt;
    int yb;
    model_bounds(c, xl, xr, yt, yb);
    return (yb - yt + 1) * (xr / NUM_BANKS - xl / NUM_BANKS + 1);
endfunction

// Pixel two places ahead in raster order, wrapping past the last pixel
function automatic pixel_t model_prefetch(input int x, input int y);
    int idx;
    idx = (y * FB_WIDTH + x + PREFETCH_OFFSET) % (FB_WIDTH * FB_HEIGHT);
    return model_frame[idx / FB_WIDTH][idx % FB_WIDTH];
endfunction

`endif

// ==== dv/renderer_tb.sv ====
`timescale 1ns/1ns

module renderer_tb import renderer_pkg::*; ();

    localparam int IDLE_TIMEOUT = 1000;                 // Cycles allowed for busy to fall
    localparam int NUM_RANDOM   = 20;                   // Random rectangles
    localparam int FRAME_PIXELS = FB_WIDTH * FB_HEIGHT;

    logic        clk_in;
    logic        rst_in;
    logic [10:0] x_in;
    logic [9:0]  y_in;
    logic        cmd_valid;
    draw_cmd_t   cmd;
    logic        busy;
    logic [3:0]  r_out;
    logic [3:0]  g_out;
    logic [3:0]  b_out;

    integer seed;                                       // $random state
    int     mismatch_count;
    int     failure_count;                              // Timeouts and protocol errors
    bit     timed_out;

    three_dim_renderer dut0 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .x_in      (x_in),
        .y_in      (y_in),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .r_out     (r_out),
        .g_out     (g_out),
        .b_out     (b_out)
    );

    `include "renderer_model.svh"

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;                    // 10 ns period
    end

    // Land just past the rising edge, where inputs change and outputs are settled
    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    // Strobe one command and mirror it in the model
    task automatic send_cmd(input draw_cmd_t c);
        if (timed_out) return;
        assert (!busy) else begin
            failure_count++;
            $display("error: command issued while the fill engine was still busy");
        end
        cmd       = c;
        cmd_valid = 1'b1;
        next_cycle();
        cmd_valid = 1'b0;
        model_apply(c);
        assert (busy) else begin
            failure_count++;
            $display("error: busy did not rise after an accepted command");
        end
    endtask

    // Count busy cycles until it falls, giving up after IDLE_TIMEOUT
    task automatic wait_idle(output int cycles);
        cycles = 0;
        while (busy && !timed_out) begin
            if (cycles == IDLE_TIMEOUT) begin
                timed_out = 1'b1;
                failure_count++;
                $display("error: busy stayed high for %0d cycles", IDLE_TIMEOUT);
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    // Run a command to completion and check how long busy stayed high
    task automatic fill_and_check(input string name, input draw_cmd_t c);
        int n;
        send_cmd(c);
        wait_idle(n);
        if (timed_out) return;
        assert (n == model_busy_cycles(c)) else begin
            mismatch_count++;
            $display("mismatch %s: busy cycles expected %0d actual %0d",
                     name, model_busy_cycles(c), n);
        end
    endtask

    // One coordinate per cycle over the whole frame, outputs lag by READ_LATENCY
    task automatic scan_frame(input string name);
        int     pending [$];                            // Raster indices in flight
        int     k;
        int     idx;
        pixel_t got;
        pixel_t exp_pix;
        if (timed_out) return;
        for (k = 0; k < FRAME_PIXELS + READ_LATENCY; k++) begin
            got = {r_out, g_out, b_out};
            if (k >= READ_LATENCY) begin
                idx     = pending.pop_front();
                exp_pix = model_prefetch(idx % FB_WIDTH, idx / FB_WIDTH);
                assert (got === exp_pix) else begin
                    mismatch_count++;
                    $display("mismatch %s: scan (%0d,%0d) expected %h actual %h",
                             name, idx % FB_WIDTH, idx / FB_WIDTH, exp_pix, got);
                end
            end
            if (k < FRAME_PIXELS) begin
                x_in = 11'(k % FB_WIDTH);
                y_in = 10'(k / FB_WIDTH);
                pending.push_back(k);
            end
            next_cycle();
        end
    endtask

    // Single coordinate, result read READ_LATENCY cycles later
    task automatic probe(input string name, input int x, input int y, input pixel_t expected);
        pixel_t got;
        if (timed_out) return;
        x_in = 11'(x);
        y_in = 10'(y);
        repeat (READ_LATENCY) next_cycle();
        got = {r_out, g_out, b_out};
        assert (got === expected) else begin
            mismatch_count++;
            $display("mismatch %s: scan (%0d,%0d) expected %h actual %h",
                     name, x, y, expected, got);
        end
    endtask

    function automatic draw_cmd_t make_cmd(input fill_op_e op, input int xa, input int xb,
                                           input int ya, input int yb, input pixel_t color);
        draw_cmd_t c;
        c.op    = op;
        c.x0    = 6'(xa);
        c.x1    = 6'(xb);
        c.y0    = 5'(ya);
        c.y1    = 5'(yb);
        c.color = color;
        return c;
    endfunction

    // Random rectangle, larger corner first when reversed
    function automatic draw_cmd_t random_rect(input bit reversed);
        int     xa;
        int     xb;
        int     ya;
        int     yb;
        pixel_t color;
        xa    = $random(seed) & (FB_WIDTH - 1);
        xb    = $random(seed) & (FB_WIDTH - 1);
        ya    = $random(seed) & (FB_HEIGHT - 1);
        yb    = $random(seed) & (FB_HEIGHT - 1);
        color = 12'($random(seed));
        if (reversed && (xa < xb)) return make_cmd(OP_FILL_RECT, xb, xa, yb, ya, color);
        return make_cmd(OP_FILL_RECT, xa, xb, ya, yb, color);
    endfunction

    initial begin
        draw_cmd_t c;
        draw_cmd_t ignored;
        pixel_t    corner_color;
        pixel_t    origin_color;
        int        n;
        seed           = 32'h6d5a600e;
        mismatch_count = 0;
        failure_count  = 0;
        timed_out      = 1'b0;
        rst_in         = 1'b1;
        x_in           = '0;
        y_in           = '0;
        cmd_valid      = 1'b0;
        cmd            = '0;
        repeat (3) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        // Reset values, before any scan data can reach the outputs
        assert (!busy && ({r_out, g_out, b_out} == '0)) else begin
            failure_count++;
            $display("error: busy or RGB outputs not cleared by reset");
        end

        c = make_cmd(OP_CLEAR, 0, 0, 0, 0, 12'($random(seed)));
        fill_and_check("clear", c);
        scan_frame("clear");

        // Wrap rule: last pixel seen two columns early, origin seen from row 31
        corner_color = ~c.color;
        origin_color = corner_color ^ 12'h5a5;          // Differs from background and corner
        fill_and_check("corner", make_cmd(OP_FILL_RECT, 63, 63, 31, 31, corner_color));
        fill_and_check("origin", make_cmd(OP_FILL_RECT, 0, 0, 0, 0, origin_color));
        probe("line_wrap", 61, 31, corner_color);
        probe("frame_wrap", 62, 31, origin_color);
        scan_frame("corners");

        // A second strobe during the fill must change nothing
        c       = make_cmd(OP_FILL_RECT, 40, 8, 4, 20, 12'($random(seed)));
        ignored = make_cmd(OP_CLEAR, 0, 0, 0, 0, ~c.color);
        send_cmd(c);
        cmd       = ignored;
        cmd_valid = 1'b1;                               // Dropped by the engine
        next_cycle();
        cmd_valid = 1'b0;
        wait_idle(n);
        assert (timed_out || (n + 1 == model_busy_cycles(c))) else begin
            mismatch_count++;
            $display("mismatch busy_strobe: busy cycles expected %0d actual %0d",
                     model_busy_cycles(c), n + 1);
        end
        scan_frame("busy_strobe");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            c = random_rect(i[0]);                      // Odd passes swap the corners
            fill_and_check($sformatf("rect_%0d", i), c);
            scan_frame($sformatf("rect_%0d", i));
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if ((mismatch_count == 0) && (failure_count == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+dv
hw/renderer_pkg.sv
hw/rect_fill_engine.sv
hw/fb_bank.sv
hw/scan_prefetch_reader.sv
hw/three_dim_renderer.sv
dv/renderer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= renderer_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
